//--- rtl/axil_split_pkg.sv
// AXI4-Lite splitter shared definitions
// Bus widths, response codes and the default peripheral address map
package axil_split_pkg;

	// Bus widths
	localparam int AXI_AW = 32;
	localparam int AXI_DW = 32;

	// Default fan-out and response FIFO depth (log2)
	localparam int NUM_SLAVES = 4;
	localparam int LGFLEN_DEF = 3;

	// AXI response code
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_SLVERR = 2'b10;
	// Interconnect error, returned for an unmapped address
	localparam resp_t RESP_DECERR = 2'b11;

	// Peripheral k lives at top nibble k, entry 0 in the low word
	localparam logic [NUM_SLAVES*AXI_AW-1:0] SLAVE_ADDR_DEF = {
		32'h3000_0000,
		32'h2000_0000,
		32'h1000_0000,
		32'h0000_0000
	};

	// Only the top nibble takes part in the compare
	localparam logic [NUM_SLAVES*AXI_AW-1:0] SLAVE_MASK_DEF = {NUM_SLAVES{32'hF000_0000}};

endpackage

//--- rtl/axil_dec_if.sv
// Decoded transaction bundle
// Carries one registered decode result from the address decoder to a path
interface axil_dec_if #(
	parameter int NS = 4
);
	localparam int LGNS = (NS > 1) ? $clog2(NS) : 1;

	// Decoder holds an entry
	logic                              valid;
	// One-hot peripheral select, zero on a miss
	logic [NS-1:0]                     sel;
	// No table entry matched
	logic                              miss;
	// Select as a binary number
	logic [LGNS-1:0]                   index;
	// Registered transaction address
	logic [axil_split_pkg::AXI_AW-1:0] addr;
	// Path holds the entry in place
	logic                              stall;

	modport dec (output valid, sel, miss, index, addr, input stall);

	modport path (input valid, sel, miss, index, addr, output stall);

endinterface

//--- rtl/axil_addr_decode.sv
// Registered address decoder
// Matches an address against the base/mask table and holds the result
// until the owning path releases it
module axil_addr_decode #(
	parameter int NS = axil_split_pkg::NUM_SLAVES,
	parameter logic [NS*axil_split_pkg::AXI_AW-1:0] SLAVE_ADDR = axil_split_pkg::SLAVE_ADDR_DEF,
	parameter logic [NS*axil_split_pkg::AXI_AW-1:0] SLAVE_MASK = axil_split_pkg::SLAVE_MASK_DEF
) (
	input  logic                              S_AXI_ACLK,
	input  logic                              S_AXI_ARESETN,
	input  logic                              i_valid,
	input  logic [axil_split_pkg::AXI_AW-1:0] i_addr,
	output logic                              o_stall,
	axil_dec_if.dec                           dec
);
	localparam int AW   = axil_split_pkg::AXI_AW;
	localparam int LGNS = (NS > 1) ? $clog2(NS) : 1;

	logic [NS-1:0]   sel_c;
	logic [LGNS-1:0] idx_c;
	logic            hit_c;
	logic            accept;

	// Busy only when an entry is held and the path refuses it
	assign o_stall = dec.valid && dec.stall;
	assign accept  = i_valid && !o_stall;

	// Table search, lowest entry wins on overlap
	always_comb
	begin
		sel_c = '0;
		idx_c = '0;
		hit_c = 1'b0;
		for (int k = 0; k < NS; k++)
		begin
			if (!hit_c && ((i_addr & SLAVE_MASK[k*AW +: AW])
					== (SLAVE_ADDR[k*AW +: AW] & SLAVE_MASK[k*AW +: AW])))
			begin
				hit_c    = 1'b1;
				sel_c[k] = 1'b1;
				idx_c    = LGNS'(k);
			end
		end
	end

	// Entry valid flag, held through a stall
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			dec.valid <= 1'b0;
		else if (accept)
			dec.valid <= 1'b1;
		else if (!dec.stall)
			dec.valid <= 1'b0;
	end

	// Decode result, only loaded on a new entry
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (accept)
		begin
			dec.sel   <= sel_c;
			dec.miss  <= !hit_c;
			dec.index <= idx_c;
			dec.addr  <= i_addr;
		end
	end

endmodule

//--- rtl/axil_resp_fifo.sv
// Response FIFO
// Circular buffer with a registered head word; depth is 2^LGFLEN
module axil_resp_fifo #(
	parameter int BW     = 2,
	parameter int LGFLEN = axil_split_pkg::LGFLEN_DEF
) (
	input  logic          S_AXI_ACLK,
	input  logic          S_AXI_ARESETN,
	input  logic          i_wr,
	input  logic [BW-1:0] i_data,
	input  logic          i_rd,
	output logic [BW-1:0] o_data,
	output logic          o_empty
);
	localparam int DEPTH = 2**LGFLEN;

	logic [BW-1:0] mem [0:DEPTH-1];

	// One extra pointer bit tells full from empty
	logic [LGFLEN:0] wr_ptr;
	logic [LGFLEN:0] rd_ptr;
	logic [LGFLEN:0] rd_next;
	logic            do_rd;

	assign o_empty = (wr_ptr == rd_ptr);

	// Pops on an empty FIFO are ignored
	assign do_rd   = i_rd && !o_empty;
	assign rd_next = rd_ptr + {{LGFLEN{1'b0}}, do_rd};

	////////////////////////////////////////
	// Pointers
	////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (i_wr)
				wr_ptr <= wr_ptr + 1'b1;
			rd_ptr <= rd_next;
		end
	end

	////////////////////////////////////////
	// Storage and head register
	////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (i_wr)
			mem[wr_ptr[LGFLEN-1:0]] <= i_data;
	end

	// Head tracks the next entry to pop
	always_ff @(posedge S_AXI_ACLK)
	begin
		// Head slot is being written right now, take the input directly
		if (i_wr && (rd_next == wr_ptr))
			o_data <= i_data;
		else
			o_data <= mem[rd_next[LGFLEN-1:0]];
	end

endmodule

//--- rtl/axil_write_path.sv
// Write half of the AXI4-Lite splitter
// Takes AW/W from the master, strobes the selected peripheral and
// returns its response on B in acceptance order
module axil_write_path #(
	parameter int NS     = axil_split_pkg::NUM_SLAVES,
	parameter int LGFLEN = axil_split_pkg::LGFLEN_DEF,
	parameter logic [NS*axil_split_pkg::AXI_AW-1:0] SLAVE_ADDR = axil_split_pkg::SLAVE_ADDR_DEF,
	parameter logic [NS*axil_split_pkg::AXI_AW-1:0] SLAVE_MASK = axil_split_pkg::SLAVE_MASK_DEF
) (
	input  logic                              S_AXI_ACLK,
	input  logic                              S_AXI_ARESETN,
	// Master side
	input  logic                              i_awvalid,
	output logic                              o_awready,
	input  logic [axil_split_pkg::AXI_AW-1:0] i_awaddr,
	input  logic                              i_wvalid,
	output logic                              o_wready,
	input  logic [axil_split_pkg::AXI_DW-1:0] i_wdata,
	output logic                              o_bvalid,
	input  logic                              i_bready,
	output logic [1:0]                        o_bresp,
	// Peripheral side
	output logic [NS-1:0]                     o_m_awvalid,
	output logic [axil_split_pkg::AXI_AW-1:0] o_m_awaddr,
	output logic [axil_split_pkg::AXI_DW-1:0] o_m_wdata,
	input  logic [NS*2-1:0]                   i_m_bresp
);
	localparam int LGNS = (NS > 1) ? $clog2(NS) : 1;

	axil_dec_if #(.NS(NS)) wdec ();

	logic                  dec_stall;
	logic                  aw_accept;
	logic                  w_done;
	logic                  b_done;
	logic                  bempty;
	logic [LGFLEN:0]       wr_count;
	logic                  wr_full;
	// Stage after the strobe
	logic                  bstb_q;
	logic                  bmiss_q;
	logic [LGNS-1:0]       bidx_q;
	// Stage feeding the FIFO
	logic                  bpush_q;
	axil_split_pkg::resp_t bresp_q;

	////////////////////////////////////////
	// AW acceptance and decode
	////////////////////////////////////////

	// Top bit of the count set means 2^LGFLEN writes in flight
	assign wr_full   = wr_count[LGFLEN];
	assign o_awready = !wr_full && !dec_stall;
	assign aw_accept = i_awvalid && o_awready;

	axil_addr_decode #(
		.NS         (NS),
		.SLAVE_ADDR (SLAVE_ADDR),
		.SLAVE_MASK (SLAVE_MASK)
	) u_wdecode (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_valid       (i_awvalid && !wr_full),
		.i_addr        (i_awaddr),
		.o_stall       (dec_stall),
		.dec           (wdec)
	);

	// Held AW waits for its data beat
	assign wdec.stall = !i_wvalid;
	assign o_wready   = wdec.valid;
	assign w_done     = i_wvalid && o_wready;

	// Peripheral write strobe, zero select on a miss
	assign o_m_awvalid = w_done ? wdec.sel : '0;
	assign o_m_awaddr  = wdec.addr;
	assign o_m_wdata   = i_wdata;

	////////////////////////////////////////
	// Response pipeline
	////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			bstb_q  <= 1'b0;
			bpush_q <= 1'b0;
		end
		else
		begin
			bstb_q  <= w_done;
			bpush_q <= bstb_q;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		bidx_q  <= wdec.index;
		bmiss_q <= wdec.miss;
		// Peripheral response is valid one cycle after its strobe
		if (bmiss_q)
			bresp_q <= axil_split_pkg::RESP_DECERR;
		else
			bresp_q <= i_m_bresp[2*bidx_q +: 2];
	end

	assign b_done   = o_bvalid && i_bready;
	assign o_bvalid = !bempty;

	axil_resp_fifo #(
		.BW     (2),
		.LGFLEN (LGFLEN)
	) u_bfifo (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_wr          (bpush_q),
		.i_data        (bresp_q),
		.i_rd          (b_done),
		.o_data        (o_bresp),
		.o_empty       (bempty)
	);

	// Writes in flight, from AW handshake to B handshake
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			wr_count <= '0;
		else if (aw_accept && !b_done)
			wr_count <= wr_count + 1'b1;
		else if (!aw_accept && b_done)
			wr_count <= wr_count - 1'b1;
	end

endmodule

//--- rtl/axil_read_path.sv
// Read half of the AXI4-Lite splitter
// Takes AR from the master, strobes the selected peripheral and
// returns its data and response on R in acceptance order
module axil_read_path #(
	parameter int NS     = axil_split_pkg::NUM_SLAVES,
	parameter int LGFLEN = axil_split_pkg::LGFLEN_DEF,
	parameter logic [NS*axil_split_pkg::AXI_AW-1:0] SLAVE_ADDR = axil_split_pkg::SLAVE_ADDR_DEF,
	parameter logic [NS*axil_split_pkg::AXI_AW-1:0] SLAVE_MASK = axil_split_pkg::SLAVE_MASK_DEF
) (
	input  logic                                 S_AXI_ACLK,
	input  logic                                 S_AXI_ARESETN,
	// Master side
	input  logic                                 i_arvalid,
	output logic                                 o_arready,
	input  logic [axil_split_pkg::AXI_AW-1:0]    i_araddr,
	output logic                                 o_rvalid,
	input  logic                                 i_rready,
	output logic [axil_split_pkg::AXI_DW-1:0]    o_rdata,
	output logic [1:0]                           o_rresp,
	// Peripheral side
	output logic [NS-1:0]                        o_m_arvalid,
	output logic [axil_split_pkg::AXI_AW-1:0]    o_m_araddr,
	input  logic [NS*axil_split_pkg::AXI_DW-1:0] i_m_rdata,
	input  logic [NS*2-1:0]                      i_m_rresp
);
	localparam int DW   = axil_split_pkg::AXI_DW;
	localparam int LGNS = (NS > 1) ? $clog2(NS) : 1;

	axil_dec_if #(.NS(NS)) rdec ();

	logic                  dec_stall;
	logic                  ar_accept;
	logic                  r_done;
	logic                  rempty;
	logic [LGFLEN:0]       rd_count;
	logic                  rd_full;
	// Stage after the strobe
	logic                  rstb_q;
	logic                  rmiss_q;
	logic [LGNS-1:0]       ridx_q;
	// Stage feeding the FIFO
	logic                  rpush_q;
	logic [DW-1:0]         rdata_q;
	axil_split_pkg::resp_t rresp_q;

	////////////////////////////////////////
	// AR acceptance and decode
	////////////////////////////////////////

	assign rd_full   = rd_count[LGFLEN];
	assign o_arready = !rd_full && !dec_stall;
	assign ar_accept = i_arvalid && o_arready;

	axil_addr_decode #(
		.NS         (NS),
		.SLAVE_ADDR (SLAVE_ADDR),
		.SLAVE_MASK (SLAVE_MASK)
	) u_rdecode (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_valid       (i_arvalid && !rd_full),
		.i_addr        (i_araddr),
		.o_stall       (dec_stall),
		.dec           (rdec)
	);

	// Peripherals answer every strobe, so nothing ever waits here
	assign rdec.stall = 1'b0;

	// Read strobe follows the decoded entry directly
	assign o_m_arvalid = rdec.valid ? rdec.sel : '0;
	assign o_m_araddr  = rdec.addr;

	////////////////////////////////////////
	// Data and response pipeline
	////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			rstb_q  <= 1'b0;
			rpush_q <= 1'b0;
		end
		else
		begin
			rstb_q  <= rdec.valid;
			rpush_q <= rstb_q;
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		ridx_q  <= rdec.index;
		rmiss_q <= rdec.miss;
		// Data comes from the peripheral strobed last cycle
		rdata_q <= i_m_rdata[DW*ridx_q +: DW];
		if (rmiss_q)
			rresp_q <= axil_split_pkg::RESP_DECERR;
		else
			rresp_q <= i_m_rresp[2*ridx_q +: 2];
	end

	assign r_done   = o_rvalid && i_rready;
	assign o_rvalid = !rempty;

	// Data and response queued as one word
	axil_resp_fifo #(
		.BW     (DW + 2),
		.LGFLEN (LGFLEN)
	) u_rfifo (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_wr          (rpush_q),
		.i_data        ({rdata_q, rresp_q}),
		.i_rd          (r_done),
		.o_data        ({o_rdata, o_rresp}),
		.o_empty       (rempty)
	);

	// Reads in flight, from AR handshake to R handshake
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_count <= '0;
		else if (ar_accept && !r_done)
			rd_count <= rd_count + 1'b1;
		else if (!ar_accept && r_done)
			rd_count <= rd_count - 1'b1;
	end

endmodule

//--- rtl/axil_split_top.sv
// AXI4-Lite splitter top level
// One AXI4-Lite slave port fanned out to NS strobe-driven peripherals
module axil_split_top #(
	parameter int NS     = axil_split_pkg::NUM_SLAVES,
	parameter int LGFLEN = axil_split_pkg::LGFLEN_DEF,
	parameter logic [NS*axil_split_pkg::AXI_AW-1:0] SLAVE_ADDR = axil_split_pkg::SLAVE_ADDR_DEF,
	parameter logic [NS*axil_split_pkg::AXI_AW-1:0] SLAVE_MASK = axil_split_pkg::SLAVE_MASK_DEF
) (
	input  logic                                 S_AXI_ACLK,
	input  logic                                 S_AXI_ARESETN,
	// AW and W
	input  logic                                 i_s_axi_awvalid,
	output logic                                 o_s_axi_awready,
	input  logic [axil_split_pkg::AXI_AW-1:0]    i_s_axi_awaddr,
	input  logic                                 i_s_axi_wvalid,
	output logic                                 o_s_axi_wready,
	input  logic [axil_split_pkg::AXI_DW-1:0]    i_s_axi_wdata,
	// B
	output logic                                 o_s_axi_bvalid,
	input  logic                                 i_s_axi_bready,
	output logic [1:0]                           o_s_axi_bresp,
	// AR
	input  logic                                 i_s_axi_arvalid,
	output logic                                 o_s_axi_arready,
	input  logic [axil_split_pkg::AXI_AW-1:0]    i_s_axi_araddr,
	// R
	output logic                                 o_s_axi_rvalid,
	input  logic                                 i_s_axi_rready,
	output logic [axil_split_pkg::AXI_DW-1:0]    o_s_axi_rdata,
	output logic [1:0]                           o_s_axi_rresp,
	// Peripheral write strobes
	output logic [NS-1:0]                        o_m_awvalid,
	output logic [axil_split_pkg::AXI_AW-1:0]    o_m_awaddr,
	output logic [axil_split_pkg::AXI_DW-1:0]    o_m_wdata,
	input  logic [NS*2-1:0]                      i_m_bresp,
	// Peripheral read strobes
	output logic [NS-1:0]                        o_m_arvalid,
	output logic [axil_split_pkg::AXI_AW-1:0]    o_m_araddr,
	input  logic [NS*axil_split_pkg::AXI_DW-1:0] i_m_rdata,
	input  logic [NS*2-1:0]                      i_m_rresp
);

	axil_write_path #(
		.NS         (NS),
		.LGFLEN     (LGFLEN),
		.SLAVE_ADDR (SLAVE_ADDR),
		.SLAVE_MASK (SLAVE_MASK)
	) u_write_path (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_awvalid     (i_s_axi_awvalid),
		.o_awready     (o_s_axi_awready),
		.i_awaddr      (i_s_axi_awaddr),
		.i_wvalid      (i_s_axi_wvalid),
		.o_wready      (o_s_axi_wready),
		.i_wdata       (i_s_axi_wdata),
		.o_bvalid      (o_s_axi_bvalid),
		.i_bready      (i_s_axi_bready),
		.o_bresp       (o_s_axi_bresp),
		.o_m_awvalid   (o_m_awvalid),
		.o_m_awaddr    (o_m_awaddr),
		.o_m_wdata     (o_m_wdata),
		.i_m_bresp     (i_m_bresp)
	);

	axil_read_path #(
		.NS         (NS),
		.LGFLEN     (LGFLEN),
		.SLAVE_ADDR (SLAVE_ADDR),
		.SLAVE_MASK (SLAVE_MASK)
	) u_read_path (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_arvalid     (i_s_axi_arvalid),
		.o_arready     (o_s_axi_arready),
		.i_araddr      (i_s_axi_araddr),
		.o_rvalid      (o_s_axi_rvalid),
		.i_rready      (i_s_axi_rready),
		.o_rdata       (o_s_axi_rdata),
		.o_rresp       (o_s_axi_rresp),
		.o_m_arvalid   (o_m_arvalid),
		.o_m_araddr    (o_m_araddr),
		.i_m_rdata     (i_m_rdata),
		.i_m_rresp     (i_m_rresp)
	);

endmodule

//--- verification/axil_split_assert.sv
// Protocol checks for the AXI4-Lite splitter
// Reset state, one-hot peripheral strobes and strobe timing
module axil_split_assert #(
	parameter int NS = 4
) (
	input logic          S_AXI_ACLK,
	input logic          S_AXI_ARESETN,
	input logic          i_wvalid,
	input logic          i_wready,
	input logic          i_arvalid,
	input logic          i_arready,
	input logic          i_awready,
	input logic          i_bvalid,
	input logic          i_rvalid,
	input logic [NS-1:0] i_m_awvalid,
	input logic [NS-1:0] i_m_arvalid
);
	// Failure count, read by the testbench
	int fail_cnt = 0;

	// First cycle out of reset
	a_reset_state: assert property (@(posedge S_AXI_ACLK)
		$rose(S_AXI_ARESETN) |-> (!i_bvalid && !i_rvalid && !i_wready
			&& (i_m_awvalid == '0) && (i_m_arvalid == '0) && i_awready && i_arready))
	else
	begin
		$error("outputs not idle after reset");
		fail_cnt++;
	end

	// At most one peripheral strobed per channel
	a_strobe_onehot: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		$onehot0(i_m_awvalid) && $onehot0(i_m_arvalid))
	else
	begin
		$error("peripheral strobe is not one-hot");
		fail_cnt++;
	end

	// Write strobe only in the W completion cycle
	a_write_strobe: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(|i_m_awvalid) |-> (i_wvalid && i_wready))
	else
	begin
		$error("write strobe outside a W handshake");
		fail_cnt++;
	end

	// Read strobe one cycle after AR handshake
	a_read_strobe: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		(|i_m_arvalid) |-> $past(i_arvalid && i_arready))
	else
	begin
		$error("read strobe without an AR handshake");
		fail_cnt++;
	end

endmodule

bind axil_split_top axil_split_assert #(.NS(NS)) u_split_assert (
	.S_AXI_ACLK    (S_AXI_ACLK),
	.S_AXI_ARESETN (S_AXI_ARESETN),
	.i_wvalid      (i_s_axi_wvalid),
	.i_wready      (o_s_axi_wready),
	.i_arvalid     (i_s_axi_arvalid),
	.i_arready     (o_s_axi_arready),
	.i_awready     (o_s_axi_awready),
	.i_bvalid      (o_s_axi_bvalid),
	.i_rvalid      (o_s_axi_rvalid),
	.i_m_awvalid   (o_m_awvalid),
	.i_m_arvalid   (o_m_arvalid)
);

//--- verification/tb_axil_split.sv
// Testbench for the AXI4-Lite splitter
// Drives the slave port, models four register peripherals and
// checks B and R responses in acceptance order
module tb_axil_split;

	localparam int NS      = axil_split_pkg::NUM_SLAVES;
	localparam int AW      = axil_split_pkg::AXI_AW;
	localparam int DW      = axil_split_pkg::AXI_DW;
	localparam int DEPTH   = 2**axil_split_pkg::LGFLEN_DEF;
	localparam int TIMEOUT = 64;

	// Peripheral response bus value outside the cycle after a strobe
	localparam axil_split_pkg::resp_t NO_RESP = 2'b01;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;

	// Master side
	logic          awvalid, awready, wvalid, wready, bvalid, bready;
	logic          arvalid, arready, rvalid, rready;
	logic [AW-1:0] awaddr, araddr;
	logic [DW-1:0] wdata, rdata;
	logic [1:0]    bresp, rresp;

	// Peripheral side
	logic [NS-1:0]    m_awvalid, m_arvalid;
	logic [AW-1:0]    m_awaddr, m_araddr;
	logic [DW-1:0]    m_wdata;
	logic [NS*2-1:0]  m_bresp, m_rresp;
	logic [NS*DW-1:0] m_rdata;

	// Peripheral registers and the expected contents
	logic [DW-1:0] periph_reg [NS][4];
	logic [DW-1:0] shadow [NS][4];
	logic [NS-1:0] aw_stb, ar_stb;
	logic [1:0]    aw_idx, ar_idx;
	logic [DW-1:0] w_val;
	int            stb_seen;
	int            stb_before;

	// Scoreboard in acceptance order
	axil_split_pkg::resp_t b_exp_q [$];
	axil_split_pkg::resp_t r_resp_q [$];
	logic [DW-1:0]         r_data_q [$];
	bit                    r_chk_q [$];

	integer        seed;
	logic [DW-1:0] data;
	string         test_name;

	axil_split_top dut (
		.S_AXI_ACLK      (S_AXI_ACLK),
		.S_AXI_ARESETN   (S_AXI_ARESETN),
		.i_s_axi_awvalid (awvalid),
		.o_s_axi_awready (awready),
		.i_s_axi_awaddr  (awaddr),
		.i_s_axi_wvalid  (wvalid),
		.o_s_axi_wready  (wready),
		.i_s_axi_wdata   (wdata),
		.o_s_axi_bvalid  (bvalid),
		.i_s_axi_bready  (bready),
		.o_s_axi_bresp   (bresp),
		.i_s_axi_arvalid (arvalid),
		.o_s_axi_arready (arready),
		.i_s_axi_araddr  (araddr),
		.o_s_axi_rvalid  (rvalid),
		.i_s_axi_rready  (rready),
		.o_s_axi_rdata   (rdata),
		.o_s_axi_rresp   (rresp),
		.o_m_awvalid     (m_awvalid),
		.o_m_awaddr      (m_awaddr),
		.o_m_wdata       (m_wdata),
		.i_m_bresp       (m_bresp),
		.o_m_arvalid     (m_arvalid),
		.o_m_araddr      (m_araddr),
		.i_m_rdata       (m_rdata),
		.i_m_rresp       (m_rresp)
	);

	always #20 S_AXI_ACLK = ~S_AXI_ACLK;

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Next drive point just after the rising edge
	task automatic step();
		@(posedge S_AXI_ACLK);
		#2;
	endtask

	task automatic report_failure(input string line);
		$display("%s", line);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [DW-1:0] exp,
			input logic [DW-1:0] act);
		assert (act === exp)
		else
			report_failure($sformatf("error %s %s: expected %h, actual %h",
				test_name, what, exp, act));
	endtask

	// Address of register r in peripheral p
	function automatic logic [AW-1:0] reg_addr(input int p, input int r);
		return {p[3:0], 24'h0, r[1:0], 2'b00};
	endfunction

	// Peripheral 2 always answers with a slave error
	function automatic axil_split_pkg::resp_t periph_resp(input int p);
		return (p == 2) ? axil_split_pkg::RESP_SLVERR : axil_split_pkg::RESP_OKAY;
	endfunction

	// AW and W are raised together and the W beat follows the AW handshake
	task automatic write_req(input logic [AW-1:0] addr, input logic [DW-1:0] val,
			input axil_split_pkg::resp_t exp);
		int t;
		b_exp_q.push_back(exp);
		awvalid = 1'b1;
		awaddr  = addr;
		wvalid  = 1'b1;
		wdata   = val;
		t = 0;
		@(negedge S_AXI_ACLK);
		while (!awready)
		begin
			t++;
			if (t > TIMEOUT)
				report_failure("timeout waiting for AWREADY");
			@(negedge S_AXI_ACLK);
		end
		step();
		awvalid = 1'b0;
		t = 0;
		@(negedge S_AXI_ACLK);
		while (!wready)
		begin
			t++;
			if (t > TIMEOUT)
				report_failure("timeout waiting for WREADY");
			@(negedge S_AXI_ACLK);
		end
		step();
		wvalid = 1'b0;
	endtask

	task automatic read_req(input logic [AW-1:0] addr, input logic [DW-1:0] exp_data,
			input axil_split_pkg::resp_t exp_resp, input bit chk);
		int t;
		r_data_q.push_back(exp_data);
		r_resp_q.push_back(exp_resp);
		r_chk_q.push_back(chk);
		arvalid = 1'b1;
		araddr  = addr;
		t = 0;
		@(negedge S_AXI_ACLK);
		while (!arready)
		begin
			t++;
			if (t > TIMEOUT)
				report_failure("timeout waiting for ARREADY");
			@(negedge S_AXI_ACLK);
		end
		step();
		arvalid = 1'b0;
	endtask

	// Takes n B responses while BREADY is high
	task automatic collect_b(input int n);
		int t;
		for (int i = 0; i < n; i++)
		begin
			t = 0;
			@(negedge S_AXI_ACLK);
			while (!bvalid)
			begin
				t++;
				if (t > TIMEOUT)
					report_failure("timeout waiting for BVALID");
				@(negedge S_AXI_ACLK);
			end
			check_value("BRESP", DW'(b_exp_q.pop_front()), DW'(bresp));
			step();
		end
	endtask

	task automatic collect_r(input int n);
		int            t;
		logic [DW-1:0] exp_data;
		for (int i = 0; i < n; i++)
		begin
			t = 0;
			@(negedge S_AXI_ACLK);
			while (!rvalid)
			begin
				t++;
				if (t > TIMEOUT)
					report_failure("timeout waiting for RVALID");
				@(negedge S_AXI_ACLK);
			end
			check_value("RRESP", DW'(r_resp_q.pop_front()), DW'(rresp));
			exp_data = r_data_q.pop_front();
			// Data is don't-care on a decode miss
			if (r_chk_q.pop_front())
				check_value("RDATA", exp_data, rdata);
			step();
		end
	endtask

	////////////////////////////////////////
	// Peripheral models
	////////////////////////////////////////

	// Strobes are sampled mid-cycle and answered after the next edge
	always
	begin
		@(negedge S_AXI_ACLK);
		aw_stb = m_awvalid;
		aw_idx = m_awaddr[3:2];
		w_val  = m_wdata;
		ar_stb = m_arvalid;
		ar_idx = m_araddr[3:2];
		step();
		for (int k = 0; k < NS; k++)
		begin
			// Responses only hold for the one cycle after a strobe
			m_bresp[2*k +: 2] = aw_stb[k] ? periph_resp(k) : NO_RESP;
			m_rresp[2*k +: 2] = ar_stb[k] ? periph_resp(k) : NO_RESP;
			if (aw_stb[k])
			begin
				periph_reg[k][aw_idx] = w_val;
				stb_seen++;
			end
			if (ar_stb[k])
			begin
				m_rdata[k*DW +: DW] = periph_reg[k][ar_idx];
				stb_seen++;
			end
		end
	end

	// Any bound assertion failure ends the run
	always @(negedge S_AXI_ACLK)
	begin
		if (dut.u_split_assert.fail_cnt != 0)
			report_failure("a protocol assertion failed");
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial
	begin
		seed = 32'h7b6d;
		S_AXI_ACLK = 1'b0;
		S_AXI_ARESETN = 1'b0;
		awvalid = 1'b0;
		awaddr  = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		bready  = 1'b0;
		arvalid = 1'b0;
		araddr  = '0;
		rready  = 1'b0;
		m_rdata = '0;
		m_bresp = {NS{NO_RESP}};
		m_rresp = {NS{NO_RESP}};
		stb_seen = 0;
		for (int k = 0; k < NS; k++)
		begin
			for (int r = 0; r < 4; r++)
				periph_reg[k][r] = '0;
		end
		repeat (10) @(posedge S_AXI_ACLK);
		#2;
		S_AXI_ARESETN = 1'b1;
		step();

		// Every register of every peripheral is written and then read back
		test_name = "write_read";
		bready = 1'b1;
		rready = 1'b1;
		for (int p = 0; p < NS; p++)
		begin
			for (int r = 0; r < 4; r++)
			begin
				data = $random(seed);
				shadow[p][r] = data;
				write_req(reg_addr(p, r), data, periph_resp(p));
				collect_b(1);
			end
		end
		for (int p = 0; p < NS; p++)
		begin
			for (int r = 0; r < 4; r++)
			begin
				read_req(reg_addr(p, r), shadow[p][r], periph_resp(p), 1'b1);
				collect_r(1);
			end
		end

		// Beyond the map there is no strobe and DECERR on both channels
		test_name = "unmapped";
		stb_before = stb_seen;
		write_req(32'h4000_0010, $random(seed), axil_split_pkg::RESP_DECERR);
		collect_b(1);
		read_req(32'hF000_0004, '0, axil_split_pkg::RESP_DECERR, 1'b0);
		collect_r(1);
		check_value("strobe count", DW'(stb_before), DW'(stb_seen));

		test_name = "slave_error";
		data = $random(seed);
		shadow[2][1] = data;
		write_req(reg_addr(2, 1), data, axil_split_pkg::RESP_SLVERR);
		collect_b(1);
		read_req(reg_addr(2, 1), data, axil_split_pkg::RESP_SLVERR, 1'b1);
		collect_r(1);

		// Eight writes fill the B FIFO and the ninth waits for BREADY
		test_name = "backpressure_write";
		bready = 1'b0;
		for (int i = 0; i <= DEPTH; i++)
		begin
			data = $random(seed);
			shadow[i % NS][i / NS] = data;
			if (i < DEPTH)
				write_req(reg_addr(i % NS, i / NS), data, periph_resp(i % NS));
		end
		fork
			write_req(reg_addr(DEPTH % NS, DEPTH / NS), data, periph_resp(DEPTH % NS));
			begin
				for (int i = 0; i < 3; i++)
				begin
					@(negedge S_AXI_ACLK);
					check_value("AWREADY", '0, DW'(awready));
					step();
				end
				bready = 1'b1;
				collect_b(DEPTH + 1);
			end
		join

		test_name = "backpressure_read";
		rready = 1'b0;
		for (int i = 0; i < DEPTH; i++)
			read_req(reg_addr(i % NS, i / NS), shadow[i % NS][i / NS],
				periph_resp(i % NS), 1'b1);
		fork
			read_req(reg_addr(DEPTH % NS, DEPTH / NS), shadow[DEPTH % NS][DEPTH / NS],
				periph_resp(DEPTH % NS), 1'b1);
			begin
				for (int i = 0; i < 3; i++)
				begin
					@(negedge S_AXI_ACLK);
					check_value("ARREADY", '0, DW'(arready));
					step();
				end
				rready = 1'b1;
				collect_r(DEPTH + 1);
			end
		join

		repeat (4) step();
		if (dut.u_split_assert.fail_cnt == 0)
		begin
			$display("Everything OK");
			$finish;
		end
		else
			report_failure("a protocol assertion failed");
	end

endmodule

//--- build.f
rtl/axil_split_pkg.sv
rtl/axil_dec_if.sv
rtl/axil_addr_decode.sv
rtl/axil_resp_fifo.sv
rtl/axil_write_path.sv
rtl/axil_read_path.sv
rtl/axil_split_top.sv
verification/axil_split_assert.sv
verification/tb_axil_split.sv

//--- Makefile
# Verilator flow for the AXI4-Lite splitter testbench

SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_axil_split
FILELIST = build.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides the result, the simulator exit code is not trusted
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Everything OK" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
